//--- hw/roce_qp_pkg.sv
package roce_qp_pkg;

  localparam int QP_COUNT  = 4;
  localparam int QP_IDX_W  = 2;
  localparam int QPN_W     = 24;
  localparam int PSN_W     = 24;
  localparam int DMA_LEN_W = 32;
  localparam int PMTU_W    = 3;

  // Must be aligned to the table size
  localparam logic [QPN_W-1:0] QPN_BASE = 24'd256;

  localparam logic [7:0] RC_ACK_OPCODE = 8'h11;

  // AETH type field, 2'b00 marks a plain ACK
  localparam logic [1:0] AETH_NAK = 2'b11;

  // PMTU code 4 is 4096 bytes, the largest MTU
  localparam logic [PMTU_W-1:0] PMTU_MAX      = 3'd4;
  localparam logic [3:0]        MTU_SHIFT_MIN = 4'd8;

  typedef enum logic [2:0] {
    QP_RESET,
    QP_INIT,
    QP_RTR,
    QP_RTS,
    QP_SQ_DRAIN,
    QP_SQ_ERROR,
    QP_ERROR
  } qp_state_e;

  typedef enum logic [2:0] {
    REQ_OPEN_QP,
    REQ_MODIFY_QP_RTS,
    REQ_CLOSE_QP
  } qp_req_e;

  typedef enum logic [1:0] {
    STATUS_OK  = 2'b00,
    STATUS_ERR = 2'b10
  } qp_status_e;

  typedef struct packed {
    qp_state_e        state;
    logic [4:0]       rsvd_hi;
    logic [31:0]      rem_ip_addr;
    logic [QPN_W-1:0] rem_qpn;
    logic [QPN_W-1:0] loc_qpn;
    logic [PSN_W-1:0] rem_psn;
    logic [PSN_W-1:0] loc_psn;
    logic [63:0]      rem_addr;
    logic [31:0]      r_key;
    logic [7:0]       syndrome;
    logic [7:0]       rsvd_lo;
  } qp_context_t;

  typedef struct packed {
    qp_req_e          req_type;
    logic [31:0]      r_key;
    logic [QPN_W-1:0] rem_qpn;
    logic [QPN_W-1:0] loc_qpn;
    logic [PSN_W-1:0] rem_psn;
    logic [PSN_W-1:0] loc_psn;
    logic [31:0]      rem_ip_addr;
    logic [63:0]      rem_addr;
  } qp_cmd_t;

  typedef struct packed {
    logic [DMA_LEN_W-1:0] dma_length;
    logic [QPN_W-1:0]     loc_qpn;
    logic [PSN_W-1:0]     rem_psn;
  } dma_meta_t;

  typedef struct packed {
    logic [7:0]       op_code;
    logic [QPN_W-1:0] dest_qp;
    logic [7:0]       syndrome;
  } rx_ack_t;

  typedef struct packed {
    logic [QP_IDX_W-1:0] idx;
    qp_context_t         ctx;
  } table_wr_t;

  typedef union packed {
    struct packed {
      logic       rsvd;
      logic [1:0] aeth_type;
      logic [4:0] credit;
    } ack;
    struct packed {
      logic       rsvd;
      logic [1:0] aeth_type;
      logic [4:0] code;
    } nak;
  } aeth_syndrome_u;

  function automatic logic qpn_valid(input logic [QPN_W-1:0] qpn);
    logic upper_ok;
    logic lower_ok;
    upper_ok = qpn[QPN_W-1:QP_IDX_W] == QPN_BASE[QPN_W-1:QP_IDX_W];
    lower_ok = int'(qpn[QP_IDX_W-1:0]) < QP_COUNT;
    return upper_ok && lower_ok;
  endfunction

endpackage

//--- hw/qp_psn_advance.sv
`timescale 1ns/1ns

module qp_psn_advance (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              start,
  input  roce_qp_pkg::dma_meta_t            meta,
  input  logic [roce_qp_pkg::PMTU_W-1:0]    pmtu,
  output logic [roce_qp_pkg::PSN_W-1:0]     psn_next
);
  import roce_qp_pkg::*;

  logic [PMTU_W-1:0]    pmtu_eff;
  logic [3:0]           mtu_shift;
  logic [DMA_LEN_W-1:0] mtu_mask;
  logic                 tail;
  logic [DMA_LEN_W-1:0] pkt_cnt;

  // Codes above 4 all mean 4096 bytes
  assign pmtu_eff  = (pmtu > PMTU_MAX) ? PMTU_MAX : pmtu;
  assign mtu_shift = MTU_SHIFT_MIN + {1'b0, pmtu_eff};
  assign mtu_mask  = (DMA_LEN_W'(1) << mtu_shift) - DMA_LEN_W'(1);

  // Ceiling division, a partial last packet still counts
  assign tail    = |(meta.dma_length & mtu_mask);
  assign pkt_cnt = (meta.dma_length >> mtu_shift) + {{(DMA_LEN_W-1){1'b0}}, tail};

  // PSN space wraps at 2^24
  always_ff @(posedge clk) begin
    if (rst) begin
      psn_next <= '0;
    end else if (start) begin
      psn_next <= meta.rem_psn + pkt_cnt[PSN_W-1:0];
    end
  end

endmodule

//--- hw/qp_context_table.sv
`timescale 1ns/1ns

module qp_context_table (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                wr_en,
  input  roce_qp_pkg::table_wr_t              wr,
  input  logic [roce_qp_pkg::QP_IDX_W-1:0]    peek_idx,
  output roce_qp_pkg::qp_context_t            peek_ctx,
  input  logic                                rd_valid,
  input  logic [roce_qp_pkg::QPN_W-1:0]       rd_qpn,
  output logic                                rd_rsp_valid,
  output logic                                rd_rsp_err,
  output roce_qp_pkg::qp_context_t            rd_ctx
);
  import roce_qp_pkg::*;

  qp_context_t entries [QP_COUNT];

  logic                rd_hit;
  logic [QP_IDX_W-1:0] rd_idx;

  // First read stage
  logic        s1_valid;
  logic        s1_err;
  qp_context_t s1_ctx;

  // Single write port, fed by the command FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < QP_COUNT; i++) begin
        entries[i] <= '0;
      end
    end else if (wr_en) begin
      entries[wr.idx] <= wr.ctx;
    end
  end

  // Current entry for the FSM rule checks
  assign peek_ctx = entries[peek_idx];

  assign rd_hit = qpn_valid(rd_qpn);
  assign rd_idx = rd_qpn[QP_IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s1_err   <= 1'b0;
    end else begin
      s1_valid <= rd_valid;
      s1_err   <= rd_valid && !rd_hit;
    end
  end

  // Out of range QPNs read back as zero
  always_ff @(posedge clk) begin
    if (rd_hit) begin
      s1_ctx <= entries[rd_idx];
    end else begin
      s1_ctx <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_rsp_valid <= 1'b0;
      rd_rsp_err   <= 1'b0;
    end else begin
      rd_rsp_valid <= s1_valid;
      rd_rsp_err   <= s1_err;
    end
  end

  always_ff @(posedge clk) begin
    rd_ctx <= s1_ctx;
  end

endmodule

//--- hw/qp_cmd_fsm.sv
`timescale 1ns/1ns

module qp_cmd_fsm (
  input  logic                                clk,
  input  logic                                rst,
  input  roce_qp_pkg::qp_cmd_t                cmd,
  input  logic                                cmd_valid,
  output logic                                cmd_ready,
  input  roce_qp_pkg::dma_meta_t              meta,
  input  logic                                meta_valid,
  output logic                                meta_ready,
  input  roce_qp_pkg::rx_ack_t                ack,
  input  logic                                ack_valid,
  output logic                                ack_ready,
  output logic                                status_valid,
  output roce_qp_pkg::qp_status_e             status,
  output logic                                psn_start,
  output roce_qp_pkg::dma_meta_t              psn_meta,
  input  logic [roce_qp_pkg::PSN_W-1:0]       psn_next,
  output logic [roce_qp_pkg::QP_IDX_W-1:0]    peek_idx,
  input  roce_qp_pkg::qp_context_t            peek_ctx,
  output logic                                wr_en,
  output roce_qp_pkg::table_wr_t              wr
);
  import roce_qp_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_OPEN,
    ST_RTS,
    ST_UPDATE,
    ST_FAIL,
    ST_CLOSE
  } fsm_state_e;

  fsm_state_e          state_q;
  fsm_state_e          state_d;
  qp_cmd_t             cmd_q;
  logic [QP_IDX_W-1:0] idx_q;
  logic [7:0]          syndrome_q;
  logic                bad_qpn_q;

  aeth_syndrome_u ack_syn;
  logic           idle_free;
  logic           ack_acc;
  logic           meta_acc;
  logic           cmd_acc;
  logic           nak_hit;
  logic           cmd_known;
  logic           cmd_state;
  logic           exec_ok;
  qp_context_t    next_ctx;

  // Stay closed while a status pulse is out
  assign idle_free  = (state_q == ST_IDLE) && !status_valid;
  assign ack_ready  = idle_free;
  assign meta_ready = idle_free && !ack_valid;
  assign cmd_ready  = idle_free && !ack_valid && !meta_valid;

  assign ack_acc  = ack_valid && ack_ready;
  assign meta_acc = meta_valid && meta_ready;
  assign cmd_acc  = cmd_valid && cmd_ready;

  // Only a real NAK with a non-zero code kills the QP
  assign ack_syn = ack.syndrome;
  assign nak_hit = (ack.op_code == RC_ACK_OPCODE) && (ack_syn.nak.aeth_type == AETH_NAK) &&
                   (ack_syn.nak.code != 5'd0) && qpn_valid(ack.dest_qp);

  assign cmd_known = cmd.req_type inside {REQ_OPEN_QP, REQ_MODIFY_QP_RTS, REQ_CLOSE_QP};

  assign psn_start = meta_acc;
  assign psn_meta  = meta;
  assign peek_idx  = idx_q;

  always_comb begin
    state_d = ST_IDLE;
    if (ack_acc) begin
      state_d = nak_hit ? ST_FAIL : ST_IDLE;
    end else if (meta_acc) begin
      state_d = qpn_valid(meta.loc_qpn) ? ST_UPDATE : ST_IDLE;
    end else if (cmd_acc) begin
      case (cmd.req_type)
        REQ_OPEN_QP:       state_d = ST_OPEN;
        REQ_MODIFY_QP_RTS: state_d = ST_RTS;
        default:           state_d = ST_CLOSE;
      endcase
    end
  end

  // Unknown request types are refused the same way as a bad QPN
  always_ff @(posedge clk) begin
    if (ack_acc) begin
      idx_q      <= ack.dest_qp[QP_IDX_W-1:0];
      syndrome_q <= ack.syndrome;
      bad_qpn_q  <= 1'b0;
    end else if (meta_acc) begin
      idx_q     <= meta.loc_qpn[QP_IDX_W-1:0];
      bad_qpn_q <= 1'b0;
    end else if (cmd_acc) begin
      idx_q     <= cmd.loc_qpn[QP_IDX_W-1:0];
      cmd_q     <= cmd;
      bad_qpn_q <= !qpn_valid(cmd.loc_qpn) || !cmd_known;
    end
  end

  assign cmd_state = (state_q == ST_OPEN) || (state_q == ST_RTS) || (state_q == ST_CLOSE);

  // Execute rules against the current entry
  always_comb begin
    next_ctx = peek_ctx;
    exec_ok  = 1'b0;
    case (state_q)
      ST_OPEN: begin
        if (peek_ctx.state == QP_RESET) begin
          next_ctx             = '0;
          next_ctx.state       = QP_INIT;
          next_ctx.rem_ip_addr = cmd_q.rem_ip_addr;
          next_ctx.rem_qpn     = cmd_q.rem_qpn;
          next_ctx.loc_qpn     = cmd_q.loc_qpn;
          next_ctx.rem_psn     = cmd_q.rem_psn;
          next_ctx.loc_psn     = cmd_q.loc_psn;
          next_ctx.rem_addr    = cmd_q.rem_addr;
          next_ctx.r_key       = cmd_q.r_key;
          exec_ok              = 1'b1;
        end
      end
      ST_RTS: begin
        if (peek_ctx.state == QP_INIT) begin
          next_ctx.state = QP_RTS;
          exec_ok        = 1'b1;
        end
      end
      ST_CLOSE: begin
        if (peek_ctx.state != QP_RESET) begin
          next_ctx.state    = QP_RESET;
          next_ctx.syndrome = 8'd0;
          exec_ok           = 1'b1;
        end
      end
      ST_UPDATE: begin
        next_ctx.rem_psn  = psn_next;
        next_ctx.syndrome = 8'd0;
        exec_ok           = 1'b1;
      end
      ST_FAIL: begin
        next_ctx.state    = QP_ERROR;
        next_ctx.syndrome = syndrome_q;
        exec_ok           = 1'b1;
      end
      default: begin
        next_ctx = peek_ctx;
      end
    endcase
  end

  assign wr_en = exec_ok && !bad_qpn_q;
  assign wr    = '{idx: idx_q, ctx: next_ctx};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= ST_IDLE;
      status_valid <= 1'b0;
    end else begin
      state_q      <= state_d;
      status_valid <= cmd_state;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_state) begin
      status <= wr_en ? STATUS_OK : STATUS_ERR;
    end
  end

endmodule

//--- hw/qp_state_top.sv
`timescale 1ns/1ns

module qp_state_top (
  input  logic                                clk,
  input  logic                                rst,
  input  roce_qp_pkg::qp_cmd_t                cmd,
  input  logic                                cmd_valid,
  output logic                                cmd_ready,
  input  roce_qp_pkg::dma_meta_t              meta,
  input  logic                                meta_valid,
  output logic                                meta_ready,
  input  roce_qp_pkg::rx_ack_t                ack,
  input  logic                                ack_valid,
  output logic                                ack_ready,
  output logic                                status_valid,
  output roce_qp_pkg::qp_status_e             status,
  input  logic [roce_qp_pkg::PMTU_W-1:0]      pmtu,
  input  logic                                rd_valid,
  input  logic [roce_qp_pkg::QPN_W-1:0]       rd_qpn,
  output logic                                rd_rsp_valid,
  output logic                                rd_rsp_err,
  output roce_qp_pkg::qp_context_t            rd_ctx
);
  import roce_qp_pkg::*;

  logic                psn_start;
  dma_meta_t           psn_meta;
  logic [PSN_W-1:0]    psn_next;
  logic [QP_IDX_W-1:0] peek_idx;
  qp_context_t         peek_ctx;
  logic                wr_en;
  table_wr_t           wr;

  qp_cmd_fsm u_fsm (
    .clk          (clk),
    .rst          (rst),
    .cmd          (cmd),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .meta         (meta),
    .meta_valid   (meta_valid),
    .meta_ready   (meta_ready),
    .ack          (ack),
    .ack_valid    (ack_valid),
    .ack_ready    (ack_ready),
    .status_valid (status_valid),
    .status       (status),
    .psn_start    (psn_start),
    .psn_meta     (psn_meta),
    .psn_next     (psn_next),
    .peek_idx     (peek_idx),
    .peek_ctx     (peek_ctx),
    .wr_en        (wr_en),
    .wr           (wr)
  );

  qp_psn_advance u_psn (
    .clk      (clk),
    .rst      (rst),
    .start    (psn_start),
    .meta     (psn_meta),
    .pmtu     (pmtu),
    .psn_next (psn_next)
  );

  qp_context_table u_table (
    .clk          (clk),
    .rst          (rst),
    .wr_en        (wr_en),
    .wr           (wr),
    .peek_idx     (peek_idx),
    .peek_ctx     (peek_ctx),
    .rd_valid     (rd_valid),
    .rd_qpn       (rd_qpn),
    .rd_rsp_valid (rd_rsp_valid),
    .rd_rsp_err   (rd_rsp_err),
    .rd_ctx       (rd_ctx)
  );

endmodule

//--- testbench/tb_qp_model.svh
`ifndef TB_QP_MODEL_SVH
`define TB_QP_MODEL_SVH

qp_context_t model_tbl [QP_COUNT];

int err_status;
int err_ctx;
int err_rsp;
int err_proto;

function automatic bit qpn_in_range(input logic [QPN_W-1:0] q);
  return (q >= QPN_BASE) && ((q - QPN_BASE) < QPN_W'(QP_COUNT));
endfunction

function automatic logic [QP_IDX_W-1:0] idx_of(input logic [QPN_W-1:0] q);
  logic [QPN_W-1:0] off;
  off = q - QPN_BASE;
  return off[QP_IDX_W-1:0];
endfunction

function automatic void model_reset();
  for (int i = 0; i < QP_COUNT; i++) begin
    model_tbl[i] = '0;
  end
endfunction

function automatic qp_status_e model_cmd(input qp_cmd_t c);
  qp_context_t e;
  if (!qpn_in_range(c.loc_qpn)) return STATUS_ERR;
  e = model_tbl[idx_of(c.loc_qpn)];
  case (c.req_type)
    REQ_OPEN_QP: begin
      if (e.state != QP_RESET) return STATUS_ERR;
      e             = '0;
      e.state       = QP_INIT;
      e.rem_ip_addr = c.rem_ip_addr;
      e.rem_qpn     = c.rem_qpn;
      e.loc_qpn     = c.loc_qpn;
      e.rem_psn     = c.rem_psn;
      e.loc_psn     = c.loc_psn;
      e.rem_addr    = c.rem_addr;
      e.r_key       = c.r_key;
    end
    REQ_MODIFY_QP_RTS: begin
      if (e.state != QP_INIT) return STATUS_ERR;
      e.state = QP_RTS;
    end
    default: begin
      if (e.state == QP_RESET) return STATUS_ERR;
      e.state    = QP_RESET;
      e.syndrome = 8'd0;
    end
  endcase
  model_tbl[idx_of(c.loc_qpn)] = e;
  return STATUS_OK;
endfunction

// Packet count by plain ceiling division
function automatic logic [PSN_W-1:0] expected_psn(input dma_meta_t m,
                                                  input logic [PMTU_W-1:0] code);
  logic [63:0] mtu;
  logic [63:0] len;
  logic [63:0] pkts;
  mtu  = 64'd256 << ((code > 3'd4) ? 3'd4 : code);
  len  = {32'd0, m.dma_length};
  pkts = (len + mtu - 64'd1) / mtu;
  return m.rem_psn + pkts[PSN_W-1:0];
endfunction

function automatic void model_meta(input dma_meta_t m, input logic [PMTU_W-1:0] code);
  if (qpn_in_range(m.loc_qpn)) begin
    model_tbl[idx_of(m.loc_qpn)].rem_psn  = expected_psn(m, code);
    model_tbl[idx_of(m.loc_qpn)].syndrome = 8'd0;
  end
endfunction

// Syndrome bits 6:5 hold the AETH type, 4:0 the NAK code
function automatic void model_ack(input rx_ack_t a);
  if (a.op_code == 8'h11 && a.syndrome[6:5] == 2'b11 && a.syndrome[4:0] != 5'd0 &&
      qpn_in_range(a.dest_qp)) begin
    model_tbl[idx_of(a.dest_qp)].state    = QP_ERROR;
    model_tbl[idx_of(a.dest_qp)].syndrome = a.syndrome;
  end
endfunction

function automatic qp_context_t model_read(input logic [QPN_W-1:0] q);
  if (!qpn_in_range(q)) return '0;
  return model_tbl[idx_of(q)];
endfunction

task automatic check_status(input qp_status_e got, input qp_status_e exp);
  if (got !== exp) begin
    err_status++;
    $display("[FAIL] status: got 0x%0h, expected 0x%0h", got, exp);
  end
endtask

task automatic check_ctx(input qp_context_t got, input qp_context_t exp);
  if (got !== exp) begin
    err_ctx++;
    $display("[FAIL] rd_ctx: got 0x%0h, expected 0x%0h", got, exp);
  end
endtask

task automatic check_rsp_err(input logic got, input logic exp);
  if (got !== exp) begin
    err_rsp++;
    $display("[FAIL] rd_rsp_err: got 0x%0h, expected 0x%0h", got, exp);
  end
endtask

`endif

//--- testbench/tb_qp_state.sv
`timescale 1ns/1ns

module tb_qp_state;
  import roce_qp_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int NUM_ITERS    = 300;
  localparam int OPS_PER_ITER = 8;
  localparam int WATCHDOG_NS  = (NUM_ITERS * OPS_PER_ITER * 10 + 100) * CLK_PERIOD;

  logic                clk;
  logic                rst;
  qp_cmd_t             cmd;
  logic                cmd_valid;
  logic                cmd_ready;
  dma_meta_t           meta;
  logic                meta_valid;
  logic                meta_ready;
  rx_ack_t             ack;
  logic                ack_valid;
  logic                ack_ready;
  logic                status_valid;
  qp_status_e          status;
  logic [PMTU_W-1:0]   pmtu;
  logic                rd_valid;
  logic [QPN_W-1:0]    rd_qpn;
  logic                rd_rsp_valid;
  logic                rd_rsp_err;
  qp_context_t         rd_ctx;

  qp_status_e  exp_status_q [$];
  qp_context_t exp_ctx_q [$];
  logic        exp_err_q [$];

  `include "tb_qp_model.svh"

  qp_state_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: no progress within %0d ns, run stopped", WATCHDOG_NS);
    $display("** FAIL **");
    $finish;
  end

  function automatic logic [QPN_W-1:0] rand_qpn();
    if ($urandom_range(0, 5) != 0) return QPN_BASE + QPN_W'($urandom_range(0, QP_COUNT - 1));
    return $urandom_range(0, 1) ? QPN_BASE + QPN_W'($urandom_range(4, 300))
                                : QPN_W'($urandom_range(0, 255));
  endfunction

  function automatic qp_cmd_t rand_cmd();
    qp_cmd_t c;
    c.req_type    = qp_req_e'(3'($urandom_range(0, 2)));
    c.r_key       = $urandom;
    c.rem_qpn     = QPN_W'($urandom);
    c.loc_qpn     = rand_qpn();
    c.rem_psn     = PSN_W'($urandom);
    c.loc_psn     = PSN_W'($urandom);
    c.rem_ip_addr = $urandom;
    c.rem_addr    = {$urandom, $urandom};
    return c;
  endfunction

  // Mix of zero, short, MTU multiples and huge lengths
  function automatic dma_meta_t rand_meta();
    dma_meta_t m;
    case ($urandom_range(0, 3))
      0: m.dma_length = 32'd0;
      1: m.dma_length = $urandom_range(1, 9000);
      2: m.dma_length = 32'($urandom_range(1, 40)) << $urandom_range(8, 12);
      default: m.dma_length = $urandom;
    endcase
    m.loc_qpn = rand_qpn();
    m.rem_psn = $urandom_range(0, 1) ? 24'hffffff - PSN_W'($urandom_range(0, 40))
                                     : PSN_W'($urandom);
    return m;
  endfunction

  function automatic rx_ack_t rand_ack();
    rx_ack_t a;
    logic [1:0] kind;
    logic [4:0] code;
    kind = $urandom_range(0, 1) ? 2'b11 : 2'($urandom_range(0, 2));
    code = ($urandom_range(0, 3) == 0) ? 5'd0 : 5'($urandom);
    a.op_code  = ($urandom_range(0, 3) != 0) ? 8'h11 : 8'($urandom);
    a.dest_qp  = rand_qpn();
    a.syndrome = {1'($urandom), kind, code};
    return a;
  endfunction

  // Raise the chosen valids and hold payloads until each one is taken
  task automatic send_events(input bit do_cmd, input bit do_meta, input bit do_ack,
                             input qp_cmd_t c, input dma_meta_t m, input rx_ack_t a);
    bit c_p;
    bit m_p;
    bit a_p;
    c_p = do_cmd;
    m_p = do_meta;
    a_p = do_ack;
    cmd = c;
    meta = m;
    ack = a;
    cmd_valid  = c_p;
    meta_valid = m_p;
    ack_valid  = a_p;
    while (c_p || m_p || a_p) begin
      @(negedge clk);
      if ((a_p && (meta_ready || cmd_ready)) || (m_p && cmd_ready)) begin
        err_proto++;
        $display("Ready was given to a lower priority stream at %0t", $time);
      end
      if (a_p && ack_ready) begin
        model_ack(a);
        a_p = 1'b0;
      end else if (m_p && meta_ready) begin
        model_meta(m, pmtu);
        m_p = 1'b0;
      end else if (c_p && cmd_ready) begin
        exp_status_q.push_back(model_cmd(c));
        c_p = 1'b0;
      end
      @(posedge clk);
      #2;
      cmd_valid  = c_p;
      meta_valid = m_p;
      ack_valid  = a_p;
    end
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (!ack_ready) @(negedge clk);
    @(posedge clk);
    #2;
  endtask

  // All valid entries back to back, then one out of range QPN
  task automatic read_all();
    logic [QPN_W-1:0] q;
    for (int i = 0; i <= QP_COUNT; i++) begin
      q = (i == QP_COUNT) ? QPN_BASE + QPN_W'($urandom_range(4, 300)) : QPN_BASE + QPN_W'(i);
      rd_valid = 1'b1;
      rd_qpn   = q;
      exp_ctx_q.push_back(model_read(q));
      exp_err_q.push_back(!qpn_in_range(q));
      @(posedge clk);
      #2;
    end
    rd_valid = 1'b0;
  endtask

  always @(negedge clk) begin
    if (!rst && status_valid) begin
      if (exp_status_q.size() == 0) begin
        err_proto++;
        $display("Status pulse seen with no command waiting for one at %0t", $time);
      end else begin
        check_status(status, exp_status_q.pop_front());
      end
    end
    if (!rst && rd_rsp_valid) begin
      if (exp_ctx_q.size() == 0) begin
        err_proto++;
        $display("Read response seen with no read outstanding at %0t", $time);
      end else begin
        check_ctx(rd_ctx, exp_ctx_q.pop_front());
        check_rsp_err(rd_rsp_err, exp_err_q.pop_front());
      end
    end
  end

  initial begin
    int kind;
    void'($urandom(72));
    rst = 1'b1;
    cmd = '0;
    cmd_valid = 1'b0;
    meta = '0;
    meta_valid = 1'b0;
    ack = '0;
    ack_valid = 1'b0;
    pmtu = '0;
    rd_valid = 1'b0;
    rd_qpn = '0;
    err_status = 0;
    err_ctx = 0;
    err_rsp = 0;
    err_proto = 0;
    model_reset();
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    if (status_valid || rd_rsp_valid || u_dut.wr_en || u_dut.psn_start) begin
      err_proto++;
      $display("Outputs were not quiet right after reset");
    end
    @(posedge clk);
    #2;
    read_all();
    for (int it = 0; it < NUM_ITERS; it++) begin
      kind = $urandom_range(0, 9);
      pmtu = 3'($urandom_range(0, 7));
      case (kind)
        0, 1, 2, 3, 4: send_events(1'b1, 1'b0, 1'b0, rand_cmd(), rand_meta(), rand_ack());
        5, 6:          send_events(1'b0, 1'b1, 1'b0, rand_cmd(), rand_meta(), rand_ack());
        7:             send_events(1'b0, 1'b0, 1'b1, rand_cmd(), rand_meta(), rand_ack());
        default:       send_events(1'b1, 1'b1, 1'b1, rand_cmd(), rand_meta(), rand_ack());
      endcase
      wait_idle();
      read_all();
    end
    while (exp_ctx_q.size() != 0 || exp_status_q.size() != 0) @(posedge clk);
    $display("Errors: status %0d, context %0d, rsp_err %0d, protocol %0d",
             err_status, err_ctx, err_rsp, err_proto);
    if (err_status + err_ctx + err_rsp + err_proto == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+testbench
hw/roce_qp_pkg.sv
hw/qp_psn_advance.sv
hw/qp_context_table.sv
hw/qp_cmd_fsm.sv
hw/qp_state_top.sv
testbench/tb_qp_state.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_qp_state -o tb_qp_state

out=$(./obj_dir/tb_qp_state)
echo "$out"

# Result is decided by the banner alone
echo "$out" | grep -q '\*\* PASS \*\*'
